/* aes_core/aes_control_unit.sv */
module aes_control_unit
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   start,
	input  logic                   disable_core,
	output aes_ctrl_pkg::ctrl_bus_t ctrl,
	output logic                   done
);
	import aes_pkg::*;
	import aes_ctrl_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;
	logic [3:0] round_cnt;
	logic round_last;
	logic [1:0] col_idx;

	// ====================
	// State register
	// ====================

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= IDLE;
		else if (disable_core)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Round 0 runs four columns, then key and columns until round 10
	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:        next_state = start ? ROUND0_COL0 : IDLE;
			ROUND0_COL0: next_state = ROUND0_COL1;
			ROUND0_COL1: next_state = ROUND0_COL2;
			ROUND0_COL2: next_state = ROUND0_COL3;
			ROUND0_COL3: next_state = ROUND_KEY;
			ROUND_KEY:   next_state = ROUND_COL0;
			ROUND_COL0:  next_state = ROUND_COL1;
			ROUND_COL1:  next_state = ROUND_COL2;
			ROUND_COL2:  next_state = ROUND_COL3;
			ROUND_COL3:  next_state = round_last ? READY : ROUND_KEY;
			READY:       next_state = IDLE;
			default:     next_state = IDLE;
		endcase
	end

	// Round counter, bumped once per key cycle
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			round_cnt <= 4'd0;
		else if (state == IDLE)
			round_cnt <= 4'd0;
		else if (state == ROUND_KEY)
			round_cnt <= round_cnt + 4'd1;
	end

	assign round_last = (round_cnt == NUM_ROUNDS);

	// done follows READY by one edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			done <= 1'b0;
		else
			done <= (state == READY);
	end

	// ====================
	// Control outputs
	// ====================

	// Column handled in the current state
	always_comb
	begin
		case (state)
			ROUND0_COL1, ROUND_COL1: col_idx = 2'd1;
			ROUND0_COL2, ROUND_COL2: col_idx = 2'd2;
			ROUND0_COL3, ROUND_COL3: col_idx = 2'd3;
			default:                 col_idx = 2'd0;
		endcase
	end

	always_comb
	begin
		ctrl.sbox_sel    = sbox_src_e'({1'b0, col_idx});
		ctrl.col_sel     = ADD_RK;
		ctrl.col_en      = 4'b0000;
		ctrl.key_next    = 1'b0;
		ctrl.key_load    = 1'b0;
		ctrl.bypass_sbox = 1'b0;
		ctrl.last_round  = 1'b0;
		ctrl.round       = round_cnt;
		case (state)
			IDLE:
			begin
				// Key and block captured on the start edge
				if (start)
				begin
					ctrl.key_load = 1'b1;
					ctrl.col_sel  = INPUT;
					ctrl.col_en   = 4'b1111;
				end
			end
			ROUND0_COL0, ROUND0_COL1, ROUND0_COL2, ROUND0_COL3:
			begin
				ctrl.bypass_sbox = 1'b1;
				ctrl.col_en      = 4'b0001 << col_idx;
			end
			ROUND_KEY:
			begin
				// S-boxes lent to the key schedule, rows shifted meanwhile
				ctrl.sbox_sel = G_FUNCTION;
				ctrl.key_next = 1'b1;
				ctrl.col_sel  = SHIFT_ROWS;
				ctrl.col_en   = 4'b1111;
			end
			ROUND_COL0, ROUND_COL1, ROUND_COL2, ROUND_COL3:
			begin
				ctrl.col_en     = 4'b0001 << col_idx;
				ctrl.last_round = round_last;
			end
			READY:
				ctrl.last_round = round_last;
			default:
				ctrl.col_en = 4'b0000;
		endcase
	end

	// ====================
	// Checks
	// ====================

	// Block finished, sequencer already back in IDLE
	assert property (@(posedge clk) disable iff (!rst_n)
		done |-> state == IDLE);

	assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.sbox_sel == G_FUNCTION |-> state == ROUND_KEY);

	assert property (@(posedge clk) disable iff (!rst_n)
		round_cnt <= NUM_ROUNDS);

endmodule

/* aes_core/aes_datapath.sv */
module aes_datapath
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,
	input  logic                    iv_load,
	input  aes_pkg::aes_mode_e      mode,
	input  aes_ctrl_pkg::ctrl_bus_t ctrl,
	input  aes_pkg::block_t         data_in,
	input  aes_pkg::block_t         iv,
	input  aes_pkg::block_t         round_key,
	input  aes_pkg::word_t          sub_word,
	output aes_pkg::word_t          sel_col,
	output aes_pkg::block_t         data_out
);
	import aes_pkg::*;
	import aes_ctrl_pkg::*;

	word_t col_q [4];
	word_t shifted [4];
	word_t rk_word [4];
	word_t base_col;
	word_t new_col;
	block_t load_blk;
	block_t state_blk;
	block_t saved_in_q;
	block_t counter_q;
	aes_mode_e mode_q;
	logic [1:0] col_idx;
	logic capture;
	logic ctr_step;

	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// One MixColumns column
	function automatic word_t mix_column(input word_t c);
		byte_t a0;
		byte_t a1;
		byte_t a2;
		byte_t a3;
		a0 = c[31:24];
		a1 = c[23:16];
		a2 = c[15:8];
		a3 = c[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	// ====================
	// Column logic
	// ====================

	assign col_idx = ctrl.sbox_sel[1:0];
	assign sel_col = col_q[col_idx];

	// Row r of column c comes from column c + r
	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			rk_word[c] = round_key[127 - 32 * c -: 32];
			shifted[c] = {col_q[c][31:24], col_q[(c + 1) % 4][23:16],
				col_q[(c + 2) % 4][15:8], col_q[(c + 3) % 4][7:0]};
		end
	end

	// Round 0 adds the raw column, the last round skips MixColumns
	assign base_col = ctrl.bypass_sbox ? sel_col : sub_word;
	assign new_col = ((ctrl.bypass_sbox || ctrl.last_round) ? base_col : mix_column(base_col))
		^ rk_word[col_idx];

	// CTR encrypts the counter instead of the data
	assign load_blk = (mode == CTR) ? counter_q : data_in;

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 4; i++)
		begin
			if (ctrl.col_en[i])
			begin
				case (ctrl.col_sel)
					INPUT:      col_q[i] <= load_blk[127 - 32 * i -: 32];
					SHIFT_ROWS: col_q[i] <= shifted[i];
					default:    col_q[i] <= new_col;
				endcase
			end
		end
	end

	// ====================
	// Mode registers
	// ====================

	assign capture = (ctrl.col_sel == INPUT) && (|ctrl.col_en);

	// READY is the only cycle with last_round set and no column enabled
	assign ctr_step = (mode_q == CTR) && ctrl.last_round && (ctrl.col_en == 4'b0000);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			mode_q <= ECB;
		else if (capture)
			mode_q <= mode;
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			saved_in_q <= data_in;
	end

	// Host load wins over the block increment
	always_ff @(posedge clk)
	begin
		if (iv_load)
			counter_q <= iv;
		else if (ctr_step)
			counter_q <= counter_q + 128'd1;
	end

	assign state_blk = {col_q[0], col_q[1], col_q[2], col_q[3]};
	assign data_out = (mode_q == CTR) ? (state_blk ^ saved_in_q) : state_blk;

	// Block capture only happens on an accepted start
	assert property (@(posedge clk) disable iff (!rst_n)
		capture |-> start);

endmodule

/* aes_core/aes_key_expander.sv */
module aes_key_expander
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  aes_ctrl_pkg::ctrl_bus_t ctrl,
	input  aes_pkg::block_t         key,
	input  aes_pkg::word_t          sub_word,
	output aes_pkg::word_t          last_word,
	output aes_pkg::block_t         round_key
);
	import aes_pkg::*;

	block_t key_q;
	word_t g_word;
	word_t w0;
	word_t w1;
	word_t w2;
	word_t w3;

	// Round constants, indexed by rounds already done
	function automatic byte_t rcon(input logic [3:0] rnd);
		case (rnd)
			4'd0:    return 8'h01;
			4'd1:    return 8'h02;
			4'd2:    return 8'h04;
			4'd3:    return 8'h08;
			4'd4:    return 8'h10;
			4'd5:    return 8'h20;
			4'd6:    return 8'h40;
			4'd7:    return 8'h80;
			4'd8:    return 8'h1b;
			4'd9:    return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

	// g result, rcon only touches the top byte
	assign g_word = sub_word ^ {rcon(ctrl.round), 24'h000000};

	// Chained word XORs give the whole next key in one cycle
	assign w0 = key_q[127:96] ^ g_word;
	assign w1 = key_q[95:64] ^ w0;
	assign w2 = key_q[63:32] ^ w1;
	assign w3 = key_q[31:0] ^ w2;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			key_q <= '0;
		else if (ctrl.key_load)
			key_q <= key;
		else if (ctrl.key_next)
			key_q <= {w0, w1, w2, w3};
	end

	// w3 feeds the S-box bank for the next g
	assign last_word = key_q[31:0];
	assign round_key = key_q;

endmodule

/* aes_core/aes_sbox_bank.sv */
module aes_sbox_bank
(
	input  aes_ctrl_pkg::ctrl_bus_t ctrl,
	input  aes_pkg::word_t          state_col,
	input  aes_pkg::word_t          key_word,
	output aes_pkg::word_t          sub_word
);
	import aes_pkg::*;
	import aes_ctrl_pkg::*;

	word_t in_word;

	// Table lookup, byte b sits at offset (255 - b) * 8
	function automatic byte_t sub_byte(input byte_t b);
		return SBOX_TABLE[{~b, 3'b000} +: 8];
	endfunction

	// g function takes the last key word rotated left by one byte
	always_comb
	begin
		if (ctrl.sbox_sel == G_FUNCTION)
			in_word = {key_word[23:0], key_word[31:24]};
		else
			in_word = state_col;
	end

	// Four byte S-boxes
	assign sub_word =
	{
		sub_byte(in_word[31:24]),
		sub_byte(in_word[23:16]),
		sub_byte(in_word[15:8]),
		sub_byte(in_word[7:0])
	};

endmodule

/* common/aes_ctrl_pkg.sv */
package aes_ctrl_pkg;

	// ====================
	// Sequencer states
	// ====================

	// Round 0 is key addition only, then key cycle plus four columns per round
	typedef enum logic [3:0]
	{
		IDLE        = 4'd0,
		ROUND0_COL0 = 4'd1,
		ROUND0_COL1 = 4'd2,
		ROUND0_COL2 = 4'd3,
		ROUND0_COL3 = 4'd4,
		ROUND_KEY   = 4'd5,
		ROUND_COL0  = 4'd6,
		ROUND_COL1  = 4'd7,
		ROUND_COL2  = 4'd8,
		ROUND_COL3  = 4'd9,
		READY       = 4'd10
	} ctrl_state_e;

	// S-box input, a state column or the g function word
	typedef enum logic [2:0]
	{
		COL_0      = 3'b000,
		COL_1      = 3'b001,
		COL_2      = 3'b010,
		COL_3      = 3'b011,
		G_FUNCTION = 3'b100
	} sbox_src_e;

	// Column register source
	typedef enum logic [1:0]
	{
		SHIFT_ROWS = 2'b00,
		ADD_RK     = 2'b01,
		INPUT      = 2'b10
	} col_src_e;

	// ====================
	// Control bus
	// ====================

	typedef struct packed
	{
		sbox_src_e  sbox_sel;
		col_src_e   col_sel;
		logic [3:0] col_en;
		logic       key_next;
		logic       key_load;
		logic       bypass_sbox;
		logic       last_round;
		logic [3:0] round;
	} ctrl_bus_t;

endpackage

/* common/aes_pkg.sv */
package aes_pkg;

	// ====================
	// Data types
	// ====================

	// One state byte
	typedef logic [7:0] byte_t;

	// One state column or one key word
	typedef logic [31:0] word_t;

	// Full block, byte 0 in the top bits as in FIPS-197
	typedef logic [127:0] block_t;

	// AES-128 round count
	localparam logic [3:0] NUM_ROUNDS = 4'd10;

	// Block modes
	typedef enum logic
	{
		ECB = 1'b0,
		CTR = 1'b1
	} aes_mode_e;

	// ====================
	// S-box table
	// ====================

	// Forward S-box, entry 0x00 in the top byte
	localparam logic [2047:0] SBOX_TABLE =
	{
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

endpackage

/* flist.f */
common/aes_pkg.sv
common/aes_ctrl_pkg.sv
aes_core/aes_control_unit.sv
aes_core/aes_sbox_bank.sv
aes_core/aes_key_expander.sv
aes_core/aes_datapath.sv
verilog/aes_top.sv
tests/aes_ref_model.sv
tests/tb_clock.sv
tests/tb_aes.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_aes -f flist.f || exit 1
out=$(./obj_dir/Vtb_aes)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* tests/aes_ref_model.sv */
package aes_ref_model;

	// ====================
	// Known vectors
	// ====================

	// FIPS-197 appendix C.1
	localparam logic [127:0] C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] C1_PT  = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

	// All-zero key and block
	localparam logic [127:0] ZERO_CT = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

	// ====================
	// Field arithmetic
	// ====================

	// Shift and add multiply, reduced by x^8 + x^4 + x^3 + x + 1
	function automatic logic [7:0] gmul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] x;
		p = 8'h00;
		x = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				p = p ^ x;
			x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	// a^254, so zero stays zero
	function automatic logic [7:0] ginv(input logic [7:0] a);
		logic [7:0] r;
		logic [7:0] s;
		r = 8'h01;
		s = a;
		for (int i = 0; i < 7; i++)
		begin
			s = gmul(s, s);
			r = gmul(r, s);
		end
		return r;
	endfunction

	// Inverse, then the affine map
	function automatic logic [7:0] sbox(input logic [7:0] a);
		logic [7:0] b;
		b = ginv(a);
		return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
			^ {b[3:0], b[7:4]} ^ 8'h63;
	endfunction

	function automatic logic [31:0] substitute_word(input logic [31:0] w);
		return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
	endfunction

	// ====================
	// Block cipher
	// ====================

	// State byte i is row i % 4 of column i / 4
	function automatic logic [127:0] encrypt(input logic [127:0] key, input logic [127:0] pt);
		logic [31:0] w [44];
		logic [7:0] s [16];
		logic [7:0] t [16];
		logic [31:0] tmp;
		logic [7:0] rc;
		logic [127:0] ct;
		rc = 8'h01;
		for (int i = 0; i < 4; i++)
			w[i] = key[127 - 32 * i -: 32];
		// Key schedule, g on every fourth word
		for (int i = 4; i < 44; i++)
		begin
			tmp = w[i - 1];
			if (i % 4 == 0)
			begin
				tmp = substitute_word({tmp[23:0], tmp[31:24]}) ^ {rc, 24'h000000};
				rc = gmul(rc, 8'h02);
			end
			w[i] = w[i - 4] ^ tmp;
		end
		for (int i = 0; i < 16; i++)
			s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
		for (int round = 1; round <= 10; round++)
		begin
			// SubBytes and ShiftRows in one pass
			for (int i = 0; i < 16; i++)
				t[i] = sbox(s[4 * ((i / 4 + i % 4) % 4) + i % 4]);
			// MixColumns except in the last round
			for (int c = 0; c < 4; c++)
			begin
				for (int r = 0; r < 4; r++)
				begin
					if (round == 10)
						s[4 * c + r] = t[4 * c + r];
					else
						s[4 * c + r] = gmul(t[4 * c + r], 8'h02)
							^ gmul(t[4 * c + (r + 1) % 4], 8'h03)
							^ t[4 * c + (r + 2) % 4] ^ t[4 * c + (r + 3) % 4];
				end
			end
			for (int i = 0; i < 16; i++)
				s[i] = s[i] ^ w[4 * round + i / 4][31 - 8 * (i % 4) -: 8];
		end
		for (int i = 0; i < 16; i++)
			ct[127 - 8 * i -: 8] = s[i];
		return ct;
	endfunction

endpackage

/* tests/tb_aes.sv */
module tb_aes;
	timeunit 1ns;
	timeprecision 100ps;

	import aes_pkg::*;
	import aes_ref_model::*;

	// Start edge to done edge
	localparam int LATENCY = 55;
	localparam int MAX_BLOCKS = 40;
	localparam int TIMEOUT_CYCLES = MAX_BLOCKS * (LATENCY + 5) + 200;

	logic clk;
	logic rst_n;
	logic start;
	logic disable_core;
	logic iv_load;
	aes_mode_e mode;
	block_t key;
	block_t data_in;
	block_t iv;
	block_t data_out;
	logic done;

	logic [63:0] rng_state;
	block_t ctr_model;
	int data_errors = 0;
	int protocol_errors = 0;
	int cycle_cnt = 0;

	tb_clock u_clock
	(
		.clk   (clk),
		.rst_n (rst_n)
	);

	aes_top i_dut
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.disable_core (disable_core),
		.iv_load      (iv_load),
		.mode         (mode),
		.key          (key),
		.data_in      (data_in),
		.iv           (iv),
		.data_out     (data_out),
		.done         (done)
	);

	// ====================
	// Helpers
	// ====================

	// xorshift64 step
	function automatic logic [63:0] xorshift();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 7);
		rng_state = rng_state ^ (rng_state << 17);
		return rng_state;
	endfunction

	function automatic block_t rand_block();
		logic [63:0] hi;
		hi = xorshift();
		return {hi, xorshift()};
	endfunction

	task automatic check_value(input string what, input block_t got, input block_t expected);
		if (got !== expected)
		begin
			data_errors++;
			$display("ERR %0t: %s got %h, expected %h", $time, what, got, expected);
		end
	endtask

	// Inputs change 10 ns after the edge
	task automatic start_block(input aes_mode_e m, input block_t k, input block_t d);
		mode = m;
		key = k;
		data_in = d;
		start = 1'b1;
		@(posedge clk);
		#10;
		start = 1'b0;
	endtask

	// Counts edges from the start edge, samples on the falling edge
	task automatic wait_done(input int elapsed, output block_t result);
		int cycles;
		logic seen;
		cycles = elapsed;
		seen = 1'b0;
		while (!seen && cycles < LATENCY + 10)
		begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
			seen = done;
		end
		result = data_out;
		if (!seen)
		begin
			protocol_errors++;
			$display("No done came within %0d cycles of start, time %0t", cycles, $time);
		end
		else if (cycles != LATENCY)
		begin
			protocol_errors++;
			$display("ERR %0t: done after %0d cycles, expected %0d", $time, cycles, LATENCY);
		end
		@(posedge clk);
		#10;
	endtask

	task automatic run_block(input aes_mode_e m, input block_t k, input block_t d,
		output block_t result);
		start_block(m, k, d);
		wait_done(0, result);
	endtask

	// Expected value from the mode rules, counter steps per CTR block
	task automatic run_checked(input aes_mode_e m, input block_t k, input block_t d,
		input string what);
		block_t expected;
		block_t got;
		if (m == CTR)
			expected = d ^ encrypt(k, ctr_model);
		else
			expected = encrypt(k, d);
		run_block(m, k, d, got);
		check_value(what, got, expected);
		if (m == CTR)
			ctr_model = ctr_model + 128'd1;
	endtask

	task automatic load_counter(input block_t b);
		iv = b;
		iv_load = 1'b1;
		@(posedge clk);
		#10;
		iv_load = 1'b0;
		ctr_model = b;
	endtask

	task automatic expect_no_done(input int cycles, input string why);
		repeat (cycles)
		begin
			@(negedge clk);
			if (done !== 1'b0)
			begin
				protocol_errors++;
				$display("ERR %0t: done high %s", $time, why);
			end
		end
		@(posedge clk);
		#10;
	endtask

	// Hang guard
	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES)
		begin
			$display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		block_t k;
		block_t d;
		block_t expected;
		block_t got;
		logic [63:0] r;
		start = 1'b0;
		disable_core = 1'b0;
		iv_load = 1'b0;
		mode = ECB;
		key = '0;
		data_in = '0;
		iv = '0;
		rng_state = 64'd7250;

		// done quiet through reset and until the first start
		while (rst_n !== 1'b1)
		begin
			@(negedge clk);
			if (done !== 1'b0)
			begin
				protocol_errors++;
				$display("ERR %0t: done high during reset", $time);
			end
		end
		expect_no_done(5, "after reset before any start");

		// Known answers, model checked too
		check_value("model C.1", encrypt(C1_KEY, C1_PT), C1_CT);
		check_value("model zero", encrypt('0, '0), ZERO_CT);
		run_block(ECB, C1_KEY, C1_PT, got);
		check_value("ECB C.1", got, C1_CT);
		run_block(ECB, '0, '0, got);
		check_value("ECB zero", got, ZERO_CT);

		for (int i = 0; i < 20; i++)
			run_checked(ECB, rand_block(), rand_block(), "ECB random");

		// Counter crossing the 2^128 wrap
		k = rand_block();
		load_counter({64'hffffffffffffffff, 64'hfffffffffffffffe});
		repeat (3) run_checked(CTR, k, rand_block(), "CTR wrap");

		// Random counter with a random mode per block
		k = rand_block();
		load_counter(rand_block());
		for (int i = 0; i < 6; i++)
		begin
			r = xorshift();
			run_checked(r[0] ? CTR : ECB, k, rand_block(), "mixed mode");
		end

		// Abort mid-block, counter must not step
		start_block(CTR, k, rand_block());
		repeat (19) @(posedge clk);
		#10;
		disable_core = 1'b1;
		@(posedge clk);
		#10;
		disable_core = 1'b0;
		expect_no_done(LATENCY + 10, "after disable_core");
		run_checked(CTR, k, rand_block(), "CTR after abort");

		// Second start while busy, new key and data must be ignored
		k = rand_block();
		d = rand_block();
		expected = encrypt(k, d);
		start_block(ECB, k, d);
		repeat (11) @(posedge clk);
		#10;
		key = rand_block();
		data_in = rand_block();
		start = 1'b1;
		@(posedge clk);
		#10;
		start = 1'b0;
		wait_done(12, got);
		check_value("ECB with busy start", got, expected);
		expect_no_done(LATENCY + 10, "after ignored start");

		$display("Errors: %0d data, %0d protocol", data_errors, protocol_errors);
		if (data_errors == 0 && protocol_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tests/tb_clock.sv */
module tb_clock
(
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held for five cycles, released off the edge
	initial
	begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		#10;
		rst_n = 1'b1;
	end

endmodule

/* verilog/aes_top.sv */
module aes_top
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               disable_core,
	input  logic               iv_load,
	input  aes_pkg::aes_mode_e mode,
	input  aes_pkg::block_t    key,
	input  aes_pkg::block_t    data_in,
	input  aes_pkg::block_t    iv,
	output aes_pkg::block_t    data_out,
	output logic               done
);
	import aes_pkg::*;
	import aes_ctrl_pkg::*;

	ctrl_bus_t ctrl;
	word_t sel_col;
	word_t last_word;
	word_t sub_word;
	block_t round_key;

	// Round sequencer
	aes_control_unit u_ctrl
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.disable_core (disable_core),
		.ctrl         (ctrl),
		.done         (done)
	);

	// S-boxes shared by state columns and key schedule
	aes_sbox_bank u_sbox
	(
		.ctrl      (ctrl),
		.state_col (sel_col),
		.key_word  (last_word),
		.sub_word  (sub_word)
	);

	aes_key_expander u_key
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.key       (key),
		.sub_word  (sub_word),
		.last_word (last_word),
		.round_key (round_key)
	);

	// Column registers and mode logic
	aes_datapath u_dp
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.iv_load   (iv_load),
		.mode      (mode),
		.ctrl      (ctrl),
		.data_in   (data_in),
		.iv        (iv),
		.round_key (round_key),
		.sub_word  (sub_word),
		.sel_col   (sel_col),
		.data_out  (data_out)
	);

endmodule
